//--- Makefile
# Verilator flow for blue_mem, every variable can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= blue_mem_tb
FILELIST  ?= blue_mem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST)

# Pass only when the run prints the pass line
sim: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf $(BUILD_DIR)

//--- blue_mem.f
common/blue_mem_pkg.sv
memory_controller/program_memory.sv
memory_controller/rng.sv
memory_controller/memory_controller.sv
verilog/video_ram.sv
verilog/blue_mem_top.sv
dv/blue_mem_properties.sv
dv/blue_mem_tb.sv

//--- common/blue_mem_pkg.sv
`default_nettype none

package blue_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Memory windows, base inclusive and top exclusive
	//////////////////////////////////////////////////////////////////////

	localparam logic [15:0] PROGRAM_TOP  = 16'h2000;
	localparam logic [15:0] SPRITE_BASE  = 16'h2000;
	localparam logic [15:0] SPRITE_TOP   = 16'h2400;
	localparam logic [15:0] TILE_BASE    = 16'h2400;
	localparam logic [15:0] TILE_TOP     = 16'h4400;
	localparam logic [15:0] PALETTE_BASE = 16'h4400;
	localparam logic [15:0] PALETTE_TOP  = 16'h4800;
	localparam logic [15:0] SOUND_BASE   = 16'h480c;
	localparam logic [15:0] SOUND_TOP    = 16'h4825;

	//////////////////////////////////////////////////////////////////////
	// Single-word registers
	//////////////////////////////////////////////////////////////////////

	localparam logic [15:0] GPU_STATUS_ADDR = 16'h4800;
	localparam logic [15:0] PRIORITY_ADDR   = 16'h4801;
	localparam logic [15:0] BRIGHTNESS_ADDR = 16'h4802;
	localparam logic [15:0] SWITCH_LED_ADDR = 16'h4803;
	localparam logic [15:0] ROT_ADDR        = 16'h4808;
	localparam logic [15:0] RNG_ADDR        = 16'h4809;
	localparam logic [15:0] CONA_ADDR       = 16'h480a;
	localparam logic [15:0] CONB_ADDR       = 16'h480b;
	localparam logic [15:0] BLANK_TIME_ADDR = 16'h4826;
	localparam logic [15:0] BG_PALETTE_ADDR = 16'h4827;

	// Word index of the four DMA registers at 4804..4807
	localparam logic [13:0] DMA_GROUP = 14'(16'h4804 >> 2);

	// Reset values
	localparam logic [7:0]  BRIGHTNESS_RESET = 8'hFF;
	localparam logic [7:0]  PRIORITY_RESET   = 8'h00;
	localparam logic [7:0]  LED_RESET        = 8'h00;
	localparam logic [15:0] RNG_RESET        = 16'hACE1;

	// Fibonacci taps 16, 14, 13, 11 as a mask on bits 15, 13, 12, 10
	localparam logic [15:0] RNG_TAPS = 16'hB400;

	// Default memory depths in words
	localparam int PROG_WORDS    = 8192;
	localparam int SPRITE_WORDS  = 1024;
	localparam int TILE_WORDS    = 8192;
	localparam int PALETTE_WORDS = 1024;

	// Bus address, seen flat or split for the DMA register decode
	typedef union packed {
		logic [15:0] flat;
		struct packed {
			logic [13:0] group;
			logic [1:0]  mode;
		} dma;
	} bus_addr_u;

endpackage

`default_nettype wire

//--- dv/blue_mem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module blue_mem_properties (
	input logic        clk,
	input logic        rst,
	input logic [15:0] memaddr,
	input logic        prog_en,
	input logic        sprite_en,
	input logic        tile_en,
	input logic        palette_en,
	input logic        sound_en,
	input logic [7:0]  brightness,
	input logic        dma_en,
	input logic [1:0]  dma_mode
);

	// Windows never overlap
	window_onehot: assert property (@(posedge clk)
		$onehot0({prog_en, sprite_en, tile_en, palette_en, sound_en}))
		else $error("more than one memory window enabled at %h", memaddr);

	brightness_reset: assert property (@(posedge clk)
		!rst |=> brightness == blue_mem_pkg::BRIGHTNESS_RESET)
		else $error("brightness not at its reset value after reset");

	// DMA register index is the low address bits
	dma_mode_match: assert property (@(posedge clk)
		dma_en |-> dma_mode == memaddr[1:0])
		else $error("dma_mode %0d does not match address %h", dma_mode, memaddr);

endmodule

bind memory_controller blue_mem_properties i_blue_mem_properties (
	.clk       (clk),
	.rst       (rst),
	.memaddr   (memaddr),
	.prog_en   (prog_en),
	.sprite_en (sprite_en),
	.tile_en   (tile_en),
	.palette_en(palette_en),
	.sound_en  (sound_en),
	.brightness(brightness),
	.dma_en    (dma_en),
	.dma_mode  (dma_mode)
);

`default_nettype wire

//--- dv/blue_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module blue_mem_tb;

	localparam logic [2:0] OP_WRITE  = 3'd0;
	localparam logic [2:0] OP_READ   = 3'd1;
	localparam logic [2:0] OP_GPU    = 3'd2;
	localparam logic [2:0] OP_OUT    = 3'd3;
	localparam logic [2:0] OP_STROBE = 3'd4;
	localparam int MAX_ROWS = 80;

	logic        clk;
	logic        rst;
	logic [15:0] memaddr;
	logic        memwrite;
	logic [15:0] writedata;
	logic [15:0] memdata;
	logic [15:0] pcaddr;
	logic [15:0] instruction;
	logic [4:0]  bg_palette;
	logic        hbright;
	logic        vbright;
	logic [7:0]  switches;
	logic [15:0] plyra_input;
	logic [15:0] plyrb_input;
	logic        blank_time_up;
	logic [15:0] rot_count;
	logic [15:0] sound_data;
	logic        bg_mem_enable;
	logic [7:0]  sprite_priority;
	logic [7:0]  brightness;
	logic [7:0]  led_out;
	logic        rot_en;
	logic        dma_en;
	logic [1:0]  dma_mode;
	logic        sound_en;
	logic [6:0]  sound_select;
	logic [9:0]  gpu_sprite_addr;
	logic [15:0] gpu_sprite_data;
	logic [12:0] gpu_tile_addr;
	logic [15:0] gpu_tile_data;
	logic [9:0]  gpu_palette_addr;
	logic [15:0] gpu_palette_data;

	// Stimulus table with one entry per row
	logic [2:0]  row_op     [MAX_ROWS];
	logic [15:0] row_addr   [MAX_ROWS];
	logic [15:0] row_data   [MAX_ROWS];
	logic [15:0] row_expect [MAX_ROWS];
	int          row_test   [MAX_ROWS];
	int          row_count;
	int          cur_test;

	// Reference model
	logic [15:0] shadow [65536];
	logic [7:0]  m_brightness;
	logic [7:0]  m_priority;
	logic [7:0]  m_led;
	logic [15:0] m_rng;
	logic [31:0] lcg_state;

	int cycles;
	int cycle_limit;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	int tests_done;

	blue_mem_top i_blue_mem_top (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: table still running after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Model functions
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] random_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Taps 16, 14, 13, 11 and the new bit enters at bit 0
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] read_model(input logic [15:0] a);
		if (a < blue_mem_pkg::PALETTE_TOP)
			return shadow[a];
		if (a >= blue_mem_pkg::SOUND_BASE && a < blue_mem_pkg::SOUND_TOP)
			return sound_data;
		case (a)
			blue_mem_pkg::GPU_STATUS_ADDR: return {14'd0, hbright, vbright};
			blue_mem_pkg::PRIORITY_ADDR:   return {8'd0, m_priority};
			blue_mem_pkg::BRIGHTNESS_ADDR: return {8'd0, m_brightness};
			blue_mem_pkg::SWITCH_LED_ADDR: return {8'd0, switches};
			blue_mem_pkg::ROT_ADDR:        return rot_count;
			blue_mem_pkg::RNG_ADDR:        return m_rng;
			blue_mem_pkg::CONA_ADDR:       return plyra_input;
			blue_mem_pkg::CONB_ADDR:       return plyrb_input;
			blue_mem_pkg::BLANK_TIME_ADDR: return {15'd0, blank_time_up};
			blue_mem_pkg::BG_PALETTE_ADDR: return {11'd0, bg_palette};
			default:                       return 16'd0;
		endcase
	endfunction

	// Packed as sound_en, sound_select, dma_en, dma_mode, rot_en, bg_mem_enable
	function automatic logic [15:0] strobe_model(input logic [15:0] a);
		logic        snd;
		logic [15:0] sel;
		snd = a >= blue_mem_pkg::SOUND_BASE && a < blue_mem_pkg::SOUND_TOP;
		sel = snd ? a - blue_mem_pkg::SOUND_BASE : 16'd0;
		return {snd, sel[6:0], a[15:2] == blue_mem_pkg::DMA_GROUP, a[1:0],
			a == blue_mem_pkg::ROT_ADDR, a == blue_mem_pkg::BG_PALETTE_ADDR, 3'd0};
	endfunction

	function automatic string test_name(input int t);
		case (t)
			0: return "reset values";
			1: return "memory readback";
			2: return "gpu and fetch ports";
			3: return "register writes";
			4: return "input reads";
			5: return "rng";
			default: return "decode strobes";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Table build and apply
	//////////////////////////////////////////////////////////////////////

	task automatic add_row(input logic [2:0] op, input logic [15:0] a, input logic [15:0] d);
		row_op[row_count]   = op;
		row_addr[row_count] = a;
		row_data[row_count] = d;
		row_test[row_count] = cur_test;
		if (op == OP_WRITE) begin
			row_expect[row_count] = d;
			case (a)
				blue_mem_pkg::BRIGHTNESS_ADDR: m_brightness = d[7:0];
				blue_mem_pkg::PRIORITY_ADDR:   m_priority = d[7:0];
				blue_mem_pkg::SWITCH_LED_ADDR: m_led = d[7:0];
				blue_mem_pkg::RNG_ADDR:        m_rng = (d == 16'd0) ? 16'h0001 : d;
				default:                       shadow[a] = d;
			endcase
		end else if (op == OP_OUT) begin
			if (a == blue_mem_pkg::BRIGHTNESS_ADDR)
				row_expect[row_count] = {8'd0, m_brightness};
			else if (a == blue_mem_pkg::PRIORITY_ADDR)
				row_expect[row_count] = {8'd0, m_priority};
			else
				row_expect[row_count] = {8'd0, m_led};
		end else if (op == OP_STROBE) begin
			row_expect[row_count] = strobe_model(a);
		end else begin
			row_expect[row_count] = read_model(a);
		end
		// Address is held over two edges and the LFSR steps twice
		if (a == blue_mem_pkg::RNG_ADDR && op != OP_WRITE)
			m_rng = lfsr_next(lfsr_next(m_rng));
		row_count++;
	endtask

	task automatic apply_row(input int i);
		logic [15:0] a;
		logic [15:0] cpu_a;
		logic [15:0] port_a;
		logic [15:0] got;
		a = row_addr[i];
		// Port under test gets the row address and the other side its inverse
		if (row_op[i] == OP_GPU) begin
			cpu_a  = ~a;
			port_a = a;
		end else begin
			cpu_a  = a;
			port_a = ~a;
		end
		@(posedge clk);
		memaddr          <= cpu_a;
		memwrite         <= row_op[i] == OP_WRITE;
		writedata        <= row_data[i];
		pcaddr           <= port_a;
		gpu_sprite_addr  <= 10'(port_a - blue_mem_pkg::SPRITE_BASE);
		gpu_tile_addr    <= 13'(port_a - blue_mem_pkg::TILE_BASE);
		gpu_palette_addr <= 10'(port_a - blue_mem_pkg::PALETTE_BASE);
		@(posedge clk);
		@(negedge clk);
		if (row_op[i] != OP_WRITE) begin
			if (row_op[i] == OP_READ) begin
				got = memdata;
			end else if (row_op[i] == OP_GPU) begin
				if (a < blue_mem_pkg::PROGRAM_TOP)
					got = instruction;
				else if (a < blue_mem_pkg::SPRITE_TOP)
					got = gpu_sprite_data;
				else if (a < blue_mem_pkg::TILE_TOP)
					got = gpu_tile_data;
				else
					got = gpu_palette_data;
			end else if (row_op[i] == OP_OUT) begin
				if (a == blue_mem_pkg::BRIGHTNESS_ADDR)
					got = {8'd0, brightness};
				else if (a == blue_mem_pkg::PRIORITY_ADDR)
					got = {8'd0, sprite_priority};
				else
					got = {8'd0, led_out};
			end else begin
				got = {sound_en, sound_select, dma_en, dma_mode, rot_en, bg_mem_enable, 3'd0};
				// Select is only meaningful inside the sound window
				if (!row_expect[i][15])
					got[14:8] = 7'd0;
			end
			test_checks++;
			if (got !== row_expect[i]) begin
				test_errors++;
				$display("error at %0t: row %0d addr %h expected %h got %h",
					$time, i, a, row_expect[i], got);
			end
		end
	endtask

	task automatic finish_test(input int t);
		$display("test %0d %s: %0d checks, %0d errors",
			t, test_name(t), test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_done++;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		logic [15:0] bounds [8];
		logic [15:0] addrs [$];
		clk = 1'b0;
		rst = 1'b0;
		memaddr = 16'd0;
		memwrite = 1'b0;
		writedata = 16'd0;
		pcaddr = 16'd0;
		gpu_sprite_addr = 10'd0;
		gpu_tile_addr = 13'd0;
		gpu_palette_addr = 10'd0;
		lcg_state = 32'hb2ba_7eb9;
		hbright = 1'b1;
		vbright = 1'b0;
		blank_time_up = 1'b1;
		switches = 8'(random_word());
		bg_palette = 5'(random_word());
		plyra_input = random_word();
		plyrb_input = random_word();
		rot_count = random_word();
		sound_data = random_word();
		m_brightness = blue_mem_pkg::BRIGHTNESS_RESET;
		m_priority = blue_mem_pkg::PRIORITY_RESET;
		m_led = blue_mem_pkg::LED_RESET;
		m_rng = blue_mem_pkg::RNG_RESET;
		row_count = 0;
		cycles = 0;
		cycle_limit = 0;
		test_checks = 0;
		test_errors = 0;
		total_checks = 0;
		total_errors = 0;
		tests_done = 0;

		cur_test = 0;
		add_row(OP_OUT, blue_mem_pkg::BRIGHTNESS_ADDR, 16'd0);
		add_row(OP_OUT, blue_mem_pkg::PRIORITY_ADDR, 16'd0);
		add_row(OP_OUT, blue_mem_pkg::SWITCH_LED_ADDR, 16'd0);
		add_row(OP_READ, blue_mem_pkg::BRIGHTNESS_ADDR, 16'd0);
		// Unmapped reads follow a nonzero read word
		add_row(OP_READ, 16'h4828, 16'd0);
		add_row(OP_READ, 16'hffff, 16'd0);
		add_row(OP_READ, blue_mem_pkg::PRIORITY_ADDR, 16'd0);

		// First and last word of each RAM window
		bounds = '{16'h0000, blue_mem_pkg::PROGRAM_TOP - 16'd1,
			blue_mem_pkg::SPRITE_BASE, blue_mem_pkg::SPRITE_TOP - 16'd1,
			blue_mem_pkg::TILE_BASE, blue_mem_pkg::TILE_TOP - 16'd1,
			blue_mem_pkg::PALETTE_BASE, blue_mem_pkg::PALETTE_TOP - 16'd1};
		cur_test = 1;
		foreach (bounds[k]) add_row(OP_WRITE, bounds[k], random_word());
		foreach (bounds[k]) add_row(OP_READ, bounds[k], 16'd0);
		cur_test = 2;
		foreach (bounds[k]) add_row(OP_GPU, bounds[k], 16'd0);

		cur_test = 3;
		addrs = '{blue_mem_pkg::BRIGHTNESS_ADDR, blue_mem_pkg::PRIORITY_ADDR,
			blue_mem_pkg::SWITCH_LED_ADDR};
		foreach (addrs[k]) begin
			add_row(OP_WRITE, addrs[k], random_word());
			add_row(OP_OUT, addrs[k], 16'd0);
			add_row(OP_READ, addrs[k], 16'd0);
		end

		cur_test = 4;
		addrs = '{blue_mem_pkg::GPU_STATUS_ADDR, blue_mem_pkg::SWITCH_LED_ADDR,
			blue_mem_pkg::CONA_ADDR, blue_mem_pkg::CONB_ADDR, blue_mem_pkg::ROT_ADDR,
			blue_mem_pkg::BG_PALETTE_ADDR, blue_mem_pkg::BLANK_TIME_ADDR,
			blue_mem_pkg::SOUND_BASE + 16'd4};
		foreach (addrs[k]) add_row(OP_READ, addrs[k], 16'd0);

		cur_test = 5;
		add_row(OP_WRITE, blue_mem_pkg::RNG_ADDR, random_word());
		add_row(OP_READ, blue_mem_pkg::RNG_ADDR, 16'd0);
		add_row(OP_READ, blue_mem_pkg::RNG_ADDR, 16'd0);
		add_row(OP_WRITE, blue_mem_pkg::RNG_ADDR, 16'd0);
		add_row(OP_READ, blue_mem_pkg::RNG_ADDR, 16'd0);
		add_row(OP_READ, blue_mem_pkg::RNG_ADDR, 16'd0);

		cur_test = 6;
		addrs = '{16'h4804, 16'h4805, 16'h4806, 16'h4807, 16'h4803,
			blue_mem_pkg::ROT_ADDR, blue_mem_pkg::BG_PALETTE_ADDR, blue_mem_pkg::SOUND_BASE,
			blue_mem_pkg::SOUND_TOP - 16'd1, blue_mem_pkg::SOUND_TOP, blue_mem_pkg::CONB_ADDR};
		foreach (addrs[k]) add_row(OP_STROBE, addrs[k], 16'd0);

		// Reset plus two cycles per row and one idle cycle
		cycle_limit = 3 * (6 + 2 * row_count);

		repeat (5) @(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < row_count; i++) begin
			apply_row(i);
			if (i == row_count - 1 || row_test[i + 1] != row_test[i])
				finish_test(row_test[i]);
		end
		@(posedge clk);
		memwrite <= 1'b0;

		$display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- memory_controller/memory_controller.sv
`timescale 1ns/1ps
`default_nettype none

module memory_controller #(
	parameter int PROG_WORDS = blue_mem_pkg::PROG_WORDS
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] memaddr,
	input  logic        memwrite,
	input  logic [15:0] writedata,
	output logic [15:0] memdata,
	input  logic [15:0] pcaddr,
	output logic [15:0] instruction,
	// Video RAM CPU ports
	input  logic [15:0] sprite_data,
	input  logic [15:0] tile_data,
	input  logic [15:0] palette_data,
	output logic        sprite_en,
	output logic        tile_en,
	output logic        palette_en,
	output logic [9:0]  sprite_addr,
	output logic [12:0] tile_addr,
	output logic [9:0]  palette_addr,
	output logic        bg_mem_enable,
	// GPU registers and status
	input  logic [4:0]  bg_palette,
	input  logic        hbright,
	input  logic        vbright,
	output logic [7:0]  sprite_priority,
	output logic [7:0]  brightness,
	// Board IO
	input  logic [7:0]  switches,
	output logic [7:0]  led_out,
	input  logic [15:0] plyra_input,
	input  logic [15:0] plyrb_input,
	input  logic        blank_time_up,
	input  logic [15:0] rot_count,
	output logic        rot_en,
	// DMA and sound windows
	output logic        dma_en,
	output logic [1:0]  dma_mode,
	input  logic [15:0] sound_data,
	output logic        sound_en,
	output logic [6:0]  sound_select
);

	blue_mem_pkg::bus_addr_u bus;
	logic        prog_en;
	logic        rng_en;
	logic [15:0] prog_rdata;
	logic [15:0] random;
	logic [15:0] read_word;

	assign bus.flat = memaddr;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	assign prog_en    = bus.flat < blue_mem_pkg::PROGRAM_TOP;
	assign sprite_en  = (bus.flat >= blue_mem_pkg::SPRITE_BASE) &&
		(bus.flat < blue_mem_pkg::SPRITE_TOP);
	assign tile_en    = (bus.flat >= blue_mem_pkg::TILE_BASE) &&
		(bus.flat < blue_mem_pkg::TILE_TOP);
	assign palette_en = (bus.flat >= blue_mem_pkg::PALETTE_BASE) &&
		(bus.flat < blue_mem_pkg::PALETTE_TOP);
	assign sound_en   = (bus.flat >= blue_mem_pkg::SOUND_BASE) &&
		(bus.flat < blue_mem_pkg::SOUND_TOP);

	// Window offsets, modulo the local width is enough inside each window
	assign sprite_addr  = bus.flat[9:0] - blue_mem_pkg::SPRITE_BASE[9:0];
	assign tile_addr    = bus.flat[12:0] - blue_mem_pkg::TILE_BASE[12:0];
	assign palette_addr = bus.flat[9:0] - blue_mem_pkg::PALETTE_BASE[9:0];
	assign sound_select = bus.flat[6:0] - blue_mem_pkg::SOUND_BASE[6:0];

	assign bg_mem_enable = bus.flat == blue_mem_pkg::BG_PALETTE_ADDR;
	assign rot_en        = bus.flat == blue_mem_pkg::ROT_ADDR;
	assign rng_en        = bus.flat == blue_mem_pkg::RNG_ADDR;

	// DMA group decode uses the split view of the address
	assign dma_en   = bus.dma.group == blue_mem_pkg::DMA_GROUP;
	assign dma_mode = bus.dma.mode;

	//////////////////////////////////////////////////////////////////////
	// Program memory and RNG
	//////////////////////////////////////////////////////////////////////

	program_memory #(
		.WORDS(PROG_WORDS)
	) i_program_memory (
		.clk        (clk),
		.en         (prog_en),
		.write      (memwrite),
		.addr       (memaddr[12:0]),
		.writedata  (writedata),
		.pcaddr     (pcaddr[12:0]),
		.rdata      (prog_rdata),
		.instruction(instruction)
	);

	rng i_rng (
		.clk   (clk),
		.rst   (rst),
		.en    (rng_en),
		.write (memwrite),
		.seed  (writedata),
		.random(random)
	);

	//////////////////////////////////////////////////////////////////////
	// Register file and read register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			brightness      <= blue_mem_pkg::BRIGHTNESS_RESET;
			sprite_priority <= blue_mem_pkg::PRIORITY_RESET;
			led_out         <= blue_mem_pkg::LED_RESET;
			read_word       <= '0;
		end else begin
			if (memwrite) begin
				case (bus.flat)
					blue_mem_pkg::BRIGHTNESS_ADDR: brightness <= writedata[7:0];
					blue_mem_pkg::PRIORITY_ADDR:   sprite_priority <= writedata[7:0];
					blue_mem_pkg::SWITCH_LED_ADDR: led_out <= writedata[7:0];
					default: ;
				endcase
			end
			// Old value wins on a read during write
			case (bus.flat)
				blue_mem_pkg::GPU_STATUS_ADDR: read_word <= {14'd0, hbright, vbright};
				blue_mem_pkg::PRIORITY_ADDR:   read_word <= {8'd0, sprite_priority};
				blue_mem_pkg::BRIGHTNESS_ADDR: read_word <= {8'd0, brightness};
				blue_mem_pkg::SWITCH_LED_ADDR: read_word <= {8'd0, switches};
				blue_mem_pkg::ROT_ADDR:        read_word <= rot_count;
				blue_mem_pkg::RNG_ADDR:        read_word <= random;
				blue_mem_pkg::CONA_ADDR:       read_word <= plyra_input;
				blue_mem_pkg::CONB_ADDR:       read_word <= plyrb_input;
				blue_mem_pkg::BLANK_TIME_ADDR: read_word <= {15'd0, blank_time_up};
				blue_mem_pkg::BG_PALETTE_ADDR: read_word <= {11'd0, bg_palette};
				default:                       read_word <= '0;
			endcase
		end
	end

	// Read select, RAM outputs first
	always_comb begin
		if (prog_en) begin
			memdata = prog_rdata;
		end else if (sprite_en) begin
			memdata = sprite_data;
		end else if (tile_en) begin
			memdata = tile_data;
		end else if (palette_en) begin
			memdata = palette_data;
		end else if (sound_en) begin
			memdata = sound_data;
		end else begin
			memdata = read_word;
		end
	end

endmodule

`default_nettype wire

//--- memory_controller/program_memory.sv
`timescale 1ns/1ps
`default_nettype none

module program_memory #(
	parameter int WORDS = blue_mem_pkg::PROG_WORDS
) (
	input  logic        clk,
	input  logic        en,
	input  logic        write,
	input  logic [12:0] addr,
	input  logic [15:0] writedata,
	input  logic [12:0] pcaddr,
	output logic [15:0] rdata,
	output logic [15:0] instruction
);

	logic [15:0] mem [WORDS];

	// Data port, read-before-write
	always_ff @(posedge clk) begin
		if (en && write) begin
			mem[addr] <= writedata;
		end
		rdata <= mem[addr];
	end

	// Fetch port
	always_ff @(posedge clk) begin
		instruction <= mem[pcaddr];
	end

endmodule

`default_nettype wire

//--- memory_controller/rng.sv
`timescale 1ns/1ps
`default_nettype none

module rng (
	input  logic        clk,
	input  logic        rst,
	input  logic        en,
	input  logic        write,
	input  logic [15:0] seed,
	output logic [15:0] random
);

	logic [15:0] lfsr;
	logic        feedback;

	assign feedback = ^(lfsr & blue_mem_pkg::RNG_TAPS);

	always_ff @(posedge clk) begin
		if (!rst) begin
			lfsr <= blue_mem_pkg::RNG_RESET;
		end else if (en) begin
			if (write) begin
				// All-zero state would lock up
				lfsr <= (seed == 16'd0) ? 16'h0001 : seed;
			end else begin
				lfsr <= {lfsr[14:0], feedback};
			end
		end
	end

	assign random = lfsr;

endmodule

`default_nettype wire

//--- verilog/blue_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module blue_mem_top #(
	parameter int PROG_WORDS    = blue_mem_pkg::PROG_WORDS,
	parameter int SPRITE_WORDS  = blue_mem_pkg::SPRITE_WORDS,
	parameter int TILE_WORDS    = blue_mem_pkg::TILE_WORDS,
	parameter int PALETTE_WORDS = blue_mem_pkg::PALETTE_WORDS
) (
	input  logic        clk,
	input  logic        rst,
	// CPU bus
	input  logic [15:0] memaddr,
	input  logic        memwrite,
	input  logic [15:0] writedata,
	output logic [15:0] memdata,
	input  logic [15:0] pcaddr,
	output logic [15:0] instruction,
	// Device inputs
	input  logic [4:0]  bg_palette,
	input  logic        hbright,
	input  logic        vbright,
	input  logic [7:0]  switches,
	input  logic [15:0] plyra_input,
	input  logic [15:0] plyrb_input,
	input  logic        blank_time_up,
	input  logic [15:0] rot_count,
	input  logic [15:0] sound_data,
	// Registers and decode strobes
	output logic        bg_mem_enable,
	output logic [7:0]  sprite_priority,
	output logic [7:0]  brightness,
	output logic [7:0]  led_out,
	output logic        rot_en,
	output logic        dma_en,
	output logic [1:0]  dma_mode,
	output logic        sound_en,
	output logic [6:0]  sound_select,
	// GPU read ports
	input  logic [9:0]  gpu_sprite_addr,
	output logic [15:0] gpu_sprite_data,
	input  logic [12:0] gpu_tile_addr,
	output logic [15:0] gpu_tile_data,
	input  logic [9:0]  gpu_palette_addr,
	output logic [15:0] gpu_palette_data
);

	logic        sprite_en;
	logic        tile_en;
	logic        palette_en;
	logic [9:0]  sprite_addr;
	logic [12:0] tile_addr;
	logic [9:0]  palette_addr;
	logic [15:0] sprite_data;
	logic [15:0] tile_data;
	logic [15:0] palette_data;

	memory_controller #(
		.PROG_WORDS(PROG_WORDS)
	) i_memory_controller (
		.clk            (clk),
		.rst            (rst),
		.memaddr        (memaddr),
		.memwrite       (memwrite),
		.writedata      (writedata),
		.memdata        (memdata),
		.pcaddr         (pcaddr),
		.instruction    (instruction),
		.sprite_data    (sprite_data),
		.tile_data      (tile_data),
		.palette_data   (palette_data),
		.sprite_en      (sprite_en),
		.tile_en        (tile_en),
		.palette_en     (palette_en),
		.sprite_addr    (sprite_addr),
		.tile_addr      (tile_addr),
		.palette_addr   (palette_addr),
		.bg_mem_enable  (bg_mem_enable),
		.bg_palette     (bg_palette),
		.hbright        (hbright),
		.vbright        (vbright),
		.sprite_priority(sprite_priority),
		.brightness     (brightness),
		.switches       (switches),
		.led_out        (led_out),
		.plyra_input    (plyra_input),
		.plyrb_input    (plyrb_input),
		.blank_time_up  (blank_time_up),
		.rot_count      (rot_count),
		.rot_en         (rot_en),
		.dma_en         (dma_en),
		.dma_mode       (dma_mode),
		.sound_data     (sound_data),
		.sound_en       (sound_en),
		.sound_select   (sound_select)
	);

	//////////////////////////////////////////////////////////////////////
	// Video RAMs, shared CPU write path
	//////////////////////////////////////////////////////////////////////

	video_ram #(
		.WORDS (SPRITE_WORDS),
		.ADDR_W(10)
	) sprite_ram (
		.clk      (clk),
		.en       (sprite_en),
		.write    (memwrite),
		.addr     (sprite_addr),
		.writedata(writedata),
		.gpu_addr (gpu_sprite_addr),
		.rdata    (sprite_data),
		.gpu_data (gpu_sprite_data)
	);

	video_ram #(
		.WORDS (TILE_WORDS),
		.ADDR_W(13)
	) tile_ram (
		.clk      (clk),
		.en       (tile_en),
		.write    (memwrite),
		.addr     (tile_addr),
		.writedata(writedata),
		.gpu_addr (gpu_tile_addr),
		.rdata    (tile_data),
		.gpu_data (gpu_tile_data)
	);

	video_ram #(
		.WORDS (PALETTE_WORDS),
		.ADDR_W(10)
	) palette_ram (
		.clk      (clk),
		.en       (palette_en),
		.write    (memwrite),
		.addr     (palette_addr),
		.writedata(writedata),
		.gpu_addr (gpu_palette_addr),
		.rdata    (palette_data),
		.gpu_data (gpu_palette_data)
	);

endmodule

`default_nettype wire

//--- verilog/video_ram.sv
`timescale 1ns/1ps
`default_nettype none

module video_ram #(
	parameter int WORDS  = 1024,
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              en,
	input  logic              write,
	input  logic [ADDR_W-1:0] addr,
	input  logic [15:0]       writedata,
	input  logic [ADDR_W-1:0] gpu_addr,
	output logic [15:0]       rdata,
	output logic [15:0]       gpu_data
);

	logic [15:0] mem [WORDS];

	// CPU side
	always_ff @(posedge clk) begin
		if (en && write) begin
			mem[addr] <= writedata;
		end
		rdata <= mem[addr];
	end

	// Pixel pipeline side, read only
	always_ff @(posedge clk) begin
		gpu_data <= mem[gpu_addr];
	end

endmodule

`default_nettype wire
